//--- logic/mutex_pkg.sv
// Resource mutex layout and shared field types for the register interlock.
package mutex_pkg;

    // One bit per tracked resource, the top bit marks a live slot.
    typedef logic [10:0] mutex_t;

    // x86 register number as encoded in ModR/M and SIB.
    typedef logic [2:0] reg_idx_t;

    typedef logic [3:0] tag_t;

    // Execute duration in cycles, 1 to 7.
    typedef logic [2:0] exe_cycles_t;

    // General registers follow the x86 encoding order.
    localparam int mutex_eax_bit    = 0;
    localparam int mutex_ecx_bit    = 1;
    localparam int mutex_edx_bit    = 2;
    localparam int mutex_ebx_bit    = 3;
    localparam int mutex_esp_bit    = 4;
    localparam int mutex_ebp_bit    = 5;
    localparam int mutex_esi_bit    = 6;
    localparam int mutex_edi_bit    = 7;
    localparam int mutex_eflags_bit = 8;
    localparam int mutex_memory_bit = 9;
    localparam int mutex_active_bit = 10;

    // All eight general registers.
    localparam mutex_t mutex_regs_mask = 11'h0ff;

endpackage

//--- logic/read_mutex.sv
// Read-stage mutex logic: resource mask of the new instruction and its hazards.
module read_mutex (
    input  logic                 req_memory, req_eflags, req_all, req_reg, req_rm,
    input  logic                 req_implicit_reg, req_reg_not_8bit,
    input  logic                 req_edi, req_esi, req_ebp, req_esp, req_ebx,
    input  logic                 req_edx_eax, req_edx, req_ecx, req_eax,
    input  mutex_pkg::reg_idx_t  implicit_reg,
    input  logic                 is_8bit,
    input  logic [1:0]           modregrm_mod,
    input  mutex_pkg::reg_idx_t  modregrm_reg,
    input  mutex_pkg::reg_idx_t  modregrm_rm,
    input  logic                 address_16bit, address_32bit,
    input  logic [7:0]           sib,
    input  mutex_pkg::mutex_t    exe_mutex,
    input  mutex_pkg::mutex_t    wr_mutex,
    input  logic                 address_bits_transform, address_xlat_transform,
    input  logic                 address_stack_pop, address_stack_pop_next,
    input  logic                 address_enter, address_enter_last, address_leave,
    input  logic                 address_esi, address_edi,
    output mutex_pkg::mutex_t    mutex_next,
    output logic                 busy_active, busy_memory, busy_eflags,
    output logic                 busy_ebp, busy_esp, busy_edx, busy_ecx, busy_eax,
    output logic                 busy_modregrm_reg, busy_modregrm_rm, busy_implicit_reg,
    output logic                 address_waiting
);

    mutex_pkg::mutex_t current;
    logic              wait_16bit;
    logic              wait_sib;
    logic              wait_32bit;
    logic              sib_has_base;
    logic              disp_only_16bit;
    logic              disp_only_32bit;

    // Byte operands 4 to 7 are AH, CH, DH, BH inside EAX to EBX.
    function automatic mutex_pkg::reg_idx_t byte_alias(input mutex_pkg::reg_idx_t idx,
                                                       input logic byte_op);
        byte_alias = (byte_op && idx[2]) ? {1'b0, idx[1:0]} : idx;
    endfunction

    always_comb begin
        mutex_next = '0;
        mutex_next[mutex_pkg::mutex_active_bit] = 1'b1;
        mutex_next[mutex_pkg::mutex_memory_bit] = req_memory;
        mutex_next[mutex_pkg::mutex_eflags_bit] = req_eflags;
        if (req_reg) begin
            mutex_next[byte_alias(modregrm_reg, is_8bit)] = 1'b1;
        end
        if (req_rm) begin
            mutex_next[byte_alias(modregrm_rm, is_8bit)] = 1'b1;
        end
        if (req_implicit_reg) begin
            mutex_next[byte_alias(implicit_reg, is_8bit)] = 1'b1;
        end
        // Full register regardless of operand size.
        if (req_reg_not_8bit) begin
            mutex_next[modregrm_reg] = 1'b1;
        end
        mutex_next[mutex_pkg::mutex_eax_bit] |= req_eax | req_edx_eax;
        mutex_next[mutex_pkg::mutex_ecx_bit] |= req_ecx;
        mutex_next[mutex_pkg::mutex_edx_bit] |= req_edx | req_edx_eax;
        mutex_next[mutex_pkg::mutex_ebx_bit] |= req_ebx;
        mutex_next[mutex_pkg::mutex_esp_bit] |= req_esp;
        mutex_next[mutex_pkg::mutex_ebp_bit] |= req_ebp;
        mutex_next[mutex_pkg::mutex_esi_bit] |= req_esi;
        mutex_next[mutex_pkg::mutex_edi_bit] |= req_edi;
        if (req_all) begin
            mutex_next = mutex_next | mutex_pkg::mutex_regs_mask;
        end
    end

    // Resources still owned by the execute or write slot.
    assign current = exe_mutex | wr_mutex;

    assign busy_active = current[mutex_pkg::mutex_active_bit];
    assign busy_memory = current[mutex_pkg::mutex_memory_bit];
    assign busy_eflags = current[mutex_pkg::mutex_eflags_bit];
    assign busy_ebp    = current[mutex_pkg::mutex_ebp_bit];
    assign busy_esp    = current[mutex_pkg::mutex_esp_bit];
    assign busy_edx    = current[mutex_pkg::mutex_edx_bit];
    assign busy_ecx    = current[mutex_pkg::mutex_ecx_bit];
    assign busy_eax    = current[mutex_pkg::mutex_eax_bit];

    assign busy_modregrm_reg = current[byte_alias(modregrm_reg, is_8bit)];
    assign busy_modregrm_rm  = current[byte_alias(modregrm_rm, is_8bit)];
    assign busy_implicit_reg = current[byte_alias(implicit_reg, is_8bit)];

    // 16-bit addressing forms.
    always_comb begin
        case (modregrm_rm)
            3'd0: wait_16bit = current[mutex_pkg::mutex_ebx_bit] | current[mutex_pkg::mutex_esi_bit];
            3'd1: wait_16bit = current[mutex_pkg::mutex_ebx_bit] | current[mutex_pkg::mutex_edi_bit];
            3'd2: wait_16bit = current[mutex_pkg::mutex_ebp_bit] | current[mutex_pkg::mutex_esi_bit];
            3'd3: wait_16bit = current[mutex_pkg::mutex_ebp_bit] | current[mutex_pkg::mutex_edi_bit];
            3'd4: wait_16bit = current[mutex_pkg::mutex_esi_bit];
            3'd5: wait_16bit = current[mutex_pkg::mutex_edi_bit];
            3'd6: wait_16bit = current[mutex_pkg::mutex_ebp_bit];
            default: wait_16bit = current[mutex_pkg::mutex_ebx_bit];
        endcase
    end

    // SIB base 5 under mod 00 is a bare displacement.
    assign sib_has_base = !(sib[2:0] == 3'd5 && modregrm_mod == 2'b00);

    // Index 4 means no index register.
    assign wait_sib = (sib[5:3] != 3'd4 && current[sib[5:3]]) ||
                      (sib_has_base && current[sib[2:0]]);

    assign wait_32bit = (modregrm_rm == 3'd4) ? wait_sib : current[modregrm_rm];

    assign disp_only_16bit = modregrm_mod == 2'b00 && modregrm_rm == 3'd6;
    assign disp_only_32bit = modregrm_mod == 2'b00 && modregrm_rm == 3'd5;

    assign address_waiting =
        (address_bits_transform && current[modregrm_reg]) ||
        (address_xlat_transform && (busy_eax || current[mutex_pkg::mutex_ebx_bit])) ||
        (address_stack_pop      && busy_esp) ||
        (address_stack_pop_next && busy_esp) ||
        (address_enter_last     && busy_esp) ||
        (address_enter          && busy_ebp) ||
        (address_leave          && busy_ebp) ||
        (address_esi            && current[mutex_pkg::mutex_esi_bit]) ||
        (address_edi            && current[mutex_pkg::mutex_edi_bit]) ||
        (address_16bit && !disp_only_16bit && wait_16bit) ||
        (address_32bit && !disp_only_32bit && wait_32bit);

endmodule

//--- logic/read_stage.sv
// Read stage: credit-fed instruction buffer with mutex-based issue control.
module read_stage #(
    parameter int BUF_DEPTH = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     req_memory, req_eflags, req_all, req_reg, req_rm,
    input  logic                     req_implicit_reg, req_reg_not_8bit,
    input  logic                     req_edi, req_esi, req_ebp, req_esp, req_ebx,
    input  logic                     req_edx_eax, req_edx, req_ecx, req_eax,
    input  mutex_pkg::reg_idx_t      implicit_reg,
    input  logic                     is_8bit,
    input  logic [1:0]               modregrm_mod,
    input  mutex_pkg::reg_idx_t      modregrm_reg,
    input  mutex_pkg::reg_idx_t      modregrm_rm,
    input  logic                     address_16bit, address_32bit,
    input  logic [7:0]               sib,
    input  logic                     address_bits_transform, address_xlat_transform,
    input  logic                     address_stack_pop, address_stack_pop_next,
    input  logic                     address_enter, address_enter_last, address_leave,
    input  logic                     address_esi, address_edi,
    input  mutex_pkg::tag_t          in_tag,
    input  mutex_pkg::exe_cycles_t   in_exe_cycles,
    input  mutex_pkg::mutex_t        exe_mutex,
    input  mutex_pkg::mutex_t        wr_mutex,
    input  logic                     exe_ready,
    output logic                     credit_return,
    output logic                     issue_valid,
    output mutex_pkg::tag_t          issue_tag,
    output mutex_pkg::mutex_t        issue_mutex,
    output mutex_pkg::exe_cycles_t   issue_exe_cycles
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    // 16 request, 9 address and 3 mode flags, then 3+2+3+3+8 fields, tag and cycles.
    localparam int ENTRY_W = 54;

    logic [ENTRY_W-1:0]     entries [BUF_DEPTH];
    logic [ENTRY_W-1:0]     in_entry;
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       fill_level;
    mutex_pkg::mutex_t      current;
    logic                   hazard;
    logic                   named_hazard;

    // Head entry fields.
    logic                   h_req_memory, h_req_eflags, h_req_all, h_req_reg, h_req_rm;
    logic                   h_req_implicit_reg, h_req_reg_not_8bit;
    logic                   h_req_edi, h_req_esi, h_req_ebp, h_req_esp, h_req_ebx;
    logic                   h_req_edx_eax, h_req_edx, h_req_ecx, h_req_eax;
    logic                   h_is_8bit, h_address_16bit, h_address_32bit;
    logic                   h_bits_transform, h_xlat_transform, h_stack_pop, h_stack_pop_next;
    logic                   h_enter, h_enter_last, h_leave, h_address_esi, h_address_edi;
    mutex_pkg::reg_idx_t    h_implicit_reg;
    mutex_pkg::reg_idx_t    h_modregrm_reg;
    mutex_pkg::reg_idx_t    h_modregrm_rm;
    logic [1:0]             h_modregrm_mod;
    logic [7:0]             h_sib;

    logic busy_active, busy_memory, busy_eflags, busy_ebp, busy_esp;
    logic busy_edx, busy_ecx, busy_eax, address_waiting;
    logic busy_modregrm_reg, busy_modregrm_rm, busy_implicit_reg;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_entry = {req_memory, req_eflags, req_all, req_reg, req_rm,
                       req_implicit_reg, req_reg_not_8bit, req_edi, req_esi, req_ebp,
                       req_esp, req_ebx, req_edx_eax, req_edx, req_ecx, req_eax,
                       is_8bit, address_16bit, address_32bit,
                       address_bits_transform, address_xlat_transform, address_stack_pop,
                       address_stack_pop_next, address_enter, address_enter_last,
                       address_leave, address_esi, address_edi,
                       implicit_reg, modregrm_mod, modregrm_reg, modregrm_rm, sib,
                       in_tag, in_exe_cycles};

    assign {h_req_memory, h_req_eflags, h_req_all, h_req_reg, h_req_rm,
            h_req_implicit_reg, h_req_reg_not_8bit, h_req_edi, h_req_esi, h_req_ebp,
            h_req_esp, h_req_ebx, h_req_edx_eax, h_req_edx, h_req_ecx, h_req_eax,
            h_is_8bit, h_address_16bit, h_address_32bit,
            h_bits_transform, h_xlat_transform, h_stack_pop,
            h_stack_pop_next, h_enter, h_enter_last,
            h_leave, h_address_esi, h_address_edi,
            h_implicit_reg, h_modregrm_mod, h_modregrm_reg, h_modregrm_rm, h_sib,
            issue_tag, issue_exe_cycles} = entries[rd_ptr];

    read_mutex u_read_mutex (
        .req_memory(h_req_memory), .req_eflags(h_req_eflags), .req_all(h_req_all),
        .req_reg(h_req_reg), .req_rm(h_req_rm), .req_implicit_reg(h_req_implicit_reg),
        .req_reg_not_8bit(h_req_reg_not_8bit), .req_edi(h_req_edi), .req_esi(h_req_esi),
        .req_ebp(h_req_ebp), .req_esp(h_req_esp), .req_ebx(h_req_ebx),
        .req_edx_eax(h_req_edx_eax), .req_edx(h_req_edx), .req_ecx(h_req_ecx),
        .req_eax(h_req_eax), .implicit_reg(h_implicit_reg), .is_8bit(h_is_8bit),
        .modregrm_mod(h_modregrm_mod), .modregrm_reg(h_modregrm_reg),
        .modregrm_rm(h_modregrm_rm), .address_16bit(h_address_16bit),
        .address_32bit(h_address_32bit), .sib(h_sib),
        .exe_mutex(exe_mutex), .wr_mutex(wr_mutex),
        .address_bits_transform(h_bits_transform), .address_xlat_transform(h_xlat_transform),
        .address_stack_pop(h_stack_pop), .address_stack_pop_next(h_stack_pop_next),
        .address_enter(h_enter), .address_enter_last(h_enter_last),
        .address_leave(h_leave), .address_esi(h_address_esi), .address_edi(h_address_edi),
        .mutex_next(issue_mutex),
        .busy_active(busy_active), .busy_memory(busy_memory), .busy_eflags(busy_eflags),
        .busy_ebp(busy_ebp), .busy_esp(busy_esp), .busy_edx(busy_edx),
        .busy_ecx(busy_ecx), .busy_eax(busy_eax),
        .busy_modregrm_reg(busy_modregrm_reg), .busy_modregrm_rm(busy_modregrm_rm),
        .busy_implicit_reg(busy_implicit_reg), .address_waiting(address_waiting)
    );

    assign current = exe_mutex | wr_mutex;

    // A full-register request waits for any older instruction.
    assign named_hazard =
        (h_req_all && busy_active) ||
        (h_req_eax && busy_eax) || (h_req_ecx && busy_ecx) || (h_req_edx && busy_edx) ||
        (h_req_edx_eax && (busy_edx || busy_eax)) ||
        (h_req_esp && busy_esp) || (h_req_ebp && busy_ebp) ||
        (h_req_ebx && current[mutex_pkg::mutex_ebx_bit]) ||
        (h_req_esi && current[mutex_pkg::mutex_esi_bit]) ||
        (h_req_edi && current[mutex_pkg::mutex_edi_bit]) ||
        (h_req_reg_not_8bit && current[h_modregrm_reg]);

    assign hazard = (busy_memory && h_req_memory) || (busy_eflags && h_req_eflags) ||
                    (busy_modregrm_reg && h_req_reg) || (busy_modregrm_rm && h_req_rm) ||
                    (busy_implicit_reg && h_req_implicit_reg) ||
                    named_hazard || address_waiting;

    assign issue_valid   = (fill_level != '0) && !hazard && exe_ready;
    assign credit_return = issue_valid;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            entries[wr_ptr] <= in_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill_level <= fill_level + CNT_W'(in_valid) - CNT_W'(issue_valid);
        end
    end

endmodule

//--- logic/exe_stage.sv
// Execute stage: one slot that holds its instruction for the stated cycle count.
module exe_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  mutex_pkg::tag_t          issue_tag,
    input  mutex_pkg::mutex_t        issue_mutex,
    input  mutex_pkg::exe_cycles_t   issue_exe_cycles,
    input  logic                     wr_ready,
    output logic                     exe_ready,
    output mutex_pkg::mutex_t        exe_mutex,
    output logic                     exe_to_wr,
    output mutex_pkg::tag_t          exe_tag
);

    typedef enum logic [1:0] {
        idle,
        count,
        hold
    } state_t;

    state_t                  state;
    mutex_pkg::exe_cycles_t  cycles_left;
    logic                    done;

    // Last counted cycle, or parked waiting for the write slot.
    assign done      = (state == count && cycles_left <= 3'd1) || state == hold;
    assign exe_to_wr = done && wr_ready;
    assign exe_ready = state == idle || exe_to_wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= idle;
            cycles_left <= '0;
            exe_mutex   <= '0;
        end else if (exe_ready) begin
            if (issue_valid) begin
                state       <= count;
                cycles_left <= issue_exe_cycles;
                exe_mutex   <= issue_mutex;
            end else begin
                state     <= idle;
                exe_mutex <= '0;
            end
        end else if (state == count) begin
            if (done) begin
                state <= hold;
            end else begin
                cycles_left <= cycles_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exe_ready && issue_valid) begin
            exe_tag <= issue_tag;
        end
    end

endmodule

//--- logic/wr_stage.sv
// Write stage: holds one cycle, three for memory writers, then retires.
module wr_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               exe_to_wr,
    input  mutex_pkg::tag_t    exe_tag,
    input  mutex_pkg::mutex_t  exe_mutex,
    output logic               wr_ready,
    output mutex_pkg::mutex_t  wr_mutex,
    output logic               retire_valid,
    output mutex_pkg::tag_t    retire_tag
);

    logic        occupied;
    logic [1:0]  extra_cycles;

    assign retire_valid = occupied && extra_cycles == 2'd0;
    // A retiring slot can take the next instruction in the same cycle.
    assign wr_ready     = !occupied || retire_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied     <= 1'b0;
            extra_cycles <= '0;
            wr_mutex     <= '0;
        end else if (exe_to_wr) begin
            occupied     <= 1'b1;
            extra_cycles <= exe_mutex[mutex_pkg::mutex_memory_bit] ? 2'd2 : 2'd0;
            wr_mutex     <= exe_mutex;
        end else if (retire_valid) begin
            occupied <= 1'b0;
            wr_mutex <= '0;
        end else if (occupied) begin
            extra_cycles <= extra_cycles - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_to_wr) begin
            retire_tag <= exe_tag;
        end
    end

endmodule

//--- logic/interlock_top.sv
// Register interlock pipeline: read buffer, execute slot and write slot.
module interlock_top #(
    parameter int BUF_DEPTH = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     req_memory, req_eflags, req_all, req_reg, req_rm,
    input  logic                     req_implicit_reg, req_reg_not_8bit,
    input  logic                     req_edi, req_esi, req_ebp, req_esp, req_ebx,
    input  logic                     req_edx_eax, req_edx, req_ecx, req_eax,
    input  mutex_pkg::reg_idx_t      implicit_reg,
    input  logic                     is_8bit,
    input  logic [1:0]               modregrm_mod,
    input  mutex_pkg::reg_idx_t      modregrm_reg,
    input  mutex_pkg::reg_idx_t      modregrm_rm,
    input  logic                     address_16bit, address_32bit,
    input  logic [7:0]               sib,
    input  logic                     address_bits_transform, address_xlat_transform,
    input  logic                     address_stack_pop, address_stack_pop_next,
    input  logic                     address_enter, address_enter_last, address_leave,
    input  logic                     address_esi, address_edi,
    input  mutex_pkg::tag_t          in_tag,
    input  mutex_pkg::exe_cycles_t   in_exe_cycles,
    output logic                     credit_return,
    output logic                     issue_valid,
    output mutex_pkg::tag_t          issue_tag,
    output mutex_pkg::mutex_t        issue_mutex,
    output logic                     retire_valid,
    output mutex_pkg::tag_t          retire_tag
);

    mutex_pkg::exe_cycles_t  issue_exe_cycles;
    mutex_pkg::mutex_t       exe_mutex;
    mutex_pkg::mutex_t       wr_mutex;
    mutex_pkg::tag_t         exe_tag;
    logic                    exe_ready;
    logic                    exe_to_wr;
    logic                    wr_ready;

    // Port names match the wires above.
    read_stage #(.BUF_DEPTH(BUF_DEPTH)) u_read_stage (.*);

    exe_stage u_exe_stage (.*);

    wr_stage u_wr_stage (.*);

endmodule

//--- verif/clock_gen.sv
// Testbench clock source with a fixed period.
module clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- verif/interlock_tb.sv
// Register interlock testbench replaying instruction cases under credit flow control.
module interlock_tb;

    localparam int BUF_DEPTH      = 2;
    localparam int CASE_WORDS     = 13;
    localparam int MAX_CASES      = 64;
    localparam int TIMEOUT_CYCLES = 3000;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic                    req_memory, req_eflags, req_all, req_reg, req_rm;
    logic                    req_implicit_reg, req_reg_not_8bit;
    logic                    req_edi, req_esi, req_ebp, req_esp, req_ebx;
    logic                    req_edx_eax, req_edx, req_ecx, req_eax;
    mutex_pkg::reg_idx_t     implicit_reg;
    logic                    is_8bit;
    logic [1:0]              modregrm_mod;
    mutex_pkg::reg_idx_t     modregrm_reg;
    mutex_pkg::reg_idx_t     modregrm_rm;
    logic                    address_16bit, address_32bit;
    logic [7:0]              sib;
    logic                    address_bits_transform, address_xlat_transform;
    logic                    address_stack_pop, address_stack_pop_next;
    logic                    address_enter, address_enter_last, address_leave;
    logic                    address_esi, address_edi;
    mutex_pkg::tag_t         in_tag;
    mutex_pkg::exe_cycles_t  in_exe_cycles;
    logic                    credit_return;
    logic                    issue_valid;
    mutex_pkg::tag_t         issue_tag;
    mutex_pkg::mutex_t       issue_mutex;
    logic                    retire_valid;
    mutex_pkg::tag_t         retire_tag;

    // Word 0 holds the case count, then CASE_WORDS words per case.
    logic [15:0]             case_mem [0:MAX_CASES*CASE_WORDS];
    logic [15:0]             fields [CASE_WORDS];
    mutex_pkg::mutex_t       in_flight [$];
    logic [31:0]             rng_state = 32'h53ca;
    int num_cases = 0;
    int sent = 0;
    int issued = 0;
    int retired = 0;
    int credits = BUF_DEPTH;
    int credit_total = 0;
    int errors = 0;
    int gap = 0;
    int cycles = 0;

    clock_gen #(.PERIOD(8)) u_clock_gen (.clk(clk));

    interlock_top #(.BUF_DEPTH(BUF_DEPTH)) UUT (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic drive_fields();
        {req_memory, req_eflags, req_all, req_reg, req_rm, req_implicit_reg, req_reg_not_8bit,
         req_edi, req_esi, req_ebp, req_esp, req_ebx, req_edx_eax, req_edx, req_ecx,
         req_eax} = fields[0];
        {address_bits_transform, address_xlat_transform, address_stack_pop,
         address_stack_pop_next, address_enter, address_enter_last, address_leave,
         address_esi, address_edi} = fields[1][8:0];
        {is_8bit, address_16bit, address_32bit} = fields[2][2:0];
        implicit_reg  = fields[3][2:0];
        modregrm_mod  = fields[4][1:0];
        modregrm_reg  = fields[5][2:0];
        modregrm_rm   = fields[6][2:0];
        sib           = fields[7][7:0];
        in_tag        = fields[8][3:0];
        in_exe_cycles = fields[9][2:0];
    endtask

    // Puts the next case on the ports and draws the idle gap after it.
    task automatic send_case();
        for (int k = 0; k < CASE_WORDS; k++) begin
            fields[k] = case_mem[1 + sent * CASE_WORDS + k];
        end
        drive_fields();
        in_valid = 1'b1;
        sent++;
        credits--;
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[1:0]);
    endtask

    // One cycle of issue, retire and credit activity against the cases.
    task automatic check_outputs();
        int                 base;
        mutex_pkg::mutex_t  dep;
        mutex_pkg::mutex_t  shared;
        base   = 1 + issued * CASE_WORDS;
        shared = '0;
        if (credit_return !== issue_valid) begin
            report_error($sformatf("credit_return %b with issue_valid %b",
                                   credit_return, issue_valid));
        end
        if (credit_return === 1'b1) begin
            credits++;
            credit_total++;
        end
        if (issue_valid === 1'b1 && issued >= sent) begin
            report_error("issue with no case waiting in the buffer");
        end else if (issue_valid === 1'b1) begin
            dep = case_mem[base + 11][10:0];
            if (issue_tag !== case_mem[base + 8][3:0]) begin
                report_error($sformatf("case %0d issued tag %h", issued, issue_tag));
            end
            if (issue_mutex !== case_mem[base + 10][10:0]) begin
                report_error($sformatf("case %0d mutex %h, expected %h",
                                       issued, issue_mutex, case_mem[base + 10][10:0]));
            end
            foreach (in_flight[k]) begin
                if ((in_flight[k] & dep) != '0) begin
                    report_error($sformatf("case %0d issued while older mutex %h overlaps %h",
                                           issued, in_flight[k], dep));
                end
                shared = shared | in_flight[k];
            end
            // Cases that must not wait name a resource an older slot still holds.
            if (case_mem[base + 12] != '0 && (shared & case_mem[base + 12][10:0]) == '0) begin
                report_error($sformatf("case %0d waited for a resource it does not use", issued));
            end
        end
        if (retire_valid === 1'b1 && in_flight.size() == 0) begin
            report_error("retire with no instruction in flight");
        end else if (retire_valid === 1'b1) begin
            if (retire_tag !== case_mem[1 + retired * CASE_WORDS + 8][3:0]) begin
                report_error($sformatf("case %0d retired tag %h", retired, retire_tag));
            end
            void'(in_flight.pop_front());
            retired++;
        end
        if (issue_valid === 1'b1 && issued < sent) begin
            in_flight.push_back(case_mem[base + 10][10:0]);
            issued++;
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        fields   = '{default: '0};
        drive_fields();
        $readmemh("verif/interlock_cases.txt", case_mem);
        num_cases = int'(case_mem[0]);
        if (num_cases < 1 || num_cases > MAX_CASES) begin
            $display("The case file gives no usable case count");
            errors++;
            num_cases = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (retired < num_cases && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            check_outputs();
            in_valid = 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (sent < num_cases && credits > 0) begin
                send_case();
            end
            // Cases sent but not yet issued must fit in the read buffer.
            if (sent - issued > BUF_DEPTH) begin
                report_error($sformatf("%0d cases waiting in a buffer of %0d",
                                       sent - issued, BUF_DEPTH));
            end
        end
        if (retired != num_cases) begin
            $display("Timeout: %0d of %0d cases retired within %0d cycles",
                     retired, num_cases, TIMEOUT_CYCLES);
            errors++;
        end
        if (credit_total != sent) begin
            report_error($sformatf("%0d credits returned for %0d sends", credit_total, sent));
        end
        $display("Error count %0d, cases sent %0d, issued %0d, retired %0d, credits %0d",
                 errors, sent, issued, retired, credit_total);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verif/interlock_cases.txt
// Columns: request flags, address flags, mode (8bit a16 a32), implicit reg, mod, reg, rm, sib,
// tag, exe cycles, expected mutex, dependence mask, mask an older slot must share at issue.
001a
5800 000 0 0 3 2 1 00 0 2 506 106 000
1800 000 4 0 3 4 7 00 1 1 409 009 000
5800 000 4 0 3 1 2 00 2 3 506 106 000
2000 000 0 0 3 0 0 00 3 4 4ff 4ff 000
4808 000 0 0 3 0 3 00 4 5 50d 10d 000
8182 000 0 0 3 0 0 00 5 2 6c2 2c2 000
0400 000 4 5 3 0 0 00 6 1 402 002 000
0a00 000 4 0 3 6 4 00 7 2 441 041 000
// Address operands behind older writers.
4800 000 0 0 3 0 3 00 8 6 508 108 000
9000 000 2 0 0 1 0 00 9 1 602 24a 000
8020 000 0 0 3 0 0 00 a 3 610 210 000
1000 060 0 0 3 2 0 00 b 1 404 014 000
4100 000 0 0 3 0 0 00 c 4 580 180 000
9000 000 1 0 1 0 4 39 d 2 601 283 000
8081 002 0 0 3 0 0 00 e 1 641 241 000
8060 010 0 0 3 0 0 00 f 2 630 230 000
0060 004 0 0 3 0 0 00 0 1 430 030 000
8001 080 0 0 3 0 0 00 1 1 601 209 000
d000 100 1 0 0 3 0 00 2 2 708 309 000
// Direct displacements issue under a memory writer of EBP.
8800 000 0 0 3 0 5 00 3 7 620 220 000
1000 000 2 0 0 0 6 00 4 1 401 001 020
8800 000 0 0 3 0 5 00 5 7 620 220 000
1000 000 1 0 0 1 5 00 6 1 402 002 020
8800 000 0 0 3 0 5 00 7 7 620 220 000
1000 000 1 0 0 2 4 25 8 1 404 004 020
1000 000 2 0 1 0 6 00 9 1 401 021 000

//--- files.f
logic/mutex_pkg.sv
logic/read_mutex.sv
logic/read_stage.sv
logic/exe_stage.sv
logic/wr_stage.sv
logic/interlock_top.sv
verif/clock_gen.sv
verif/interlock_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the interlock testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module interlock_tb -f files.f || exit 1
output=$(./obj_dir/Vinterlock_tb)
echo "$output"
echo "$output" | grep -qx "Finished with no errors" && exit 0 || exit 1
